// File: mem_if_pkg.sv
/* Dual-port memory interface definitions */

package mem_if_pkg;

  // ------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------

  // Data word, shared by the AXI side and the memory array
  localparam int DATA_WIDTH = 32;

  // One strobe bit per byte lane
  localparam int STRB_WIDTH = DATA_WIDTH / 8;

  // Full AXI byte address
  localparam int ADDR_WIDTH = 32;

  // Low address bits that pick a byte inside a word
  localparam int OFFSET_BITS = 2;

  // ------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------

  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef logic [STRB_WIDTH-1:0] strb_t;

  // ------------------------------------------------------------------
  // Response codes
  // ------------------------------------------------------------------

  // Only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// File: axil_port_slave.sv
/* AXI4-Lite port front end */

`timescale 1ns/1ps

module axil_port_slave
  import mem_if_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
)
(
  input  logic                      ACLK,
  input  logic                      ARESETn,

  // Write address channel
  input  logic [ADDR_WIDTH-1:0]     s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,

  // Write data channel
  input  data_t                     s_wdata_i,
  input  strb_t                     s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,

  // Write response channel
  output logic [1:0]                s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,

  // Read address channel
  input  logic [ADDR_WIDTH-1:0]     s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,

  // Read data channel
  output data_t                     s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,

  // Request to arbiter
  output logic                      req_valid_o,
  output logic                      req_write_o,
  output logic [MEM_ADDR_WIDTH-1:0] req_addr_o,
  output data_t                     req_wdata_o,
  output strb_t                     req_be_o,

  // Answer from arbiter and memory
  input  logic                      grant_i,
  input  logic                      rdata_valid_i,
  input  data_t                     rdata_i
);

  // Slot flags
  logic aw_full;
  logic w_full;
  logic ar_full;

  // Slot payloads
  logic [MEM_ADDR_WIDTH-1:0] aw_addr;
  logic [MEM_ADDR_WIDTH-1:0] ar_addr;
  data_t                     w_data;
  strb_t                     w_strb;

  // Response side
  logic  bvalid;
  logic  rvalid;
  logic  rd_pending;
  data_t r_data;

  // Round robin, 0 favours the write
  logic rr_flag;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic b_hs;
  logic r_hs;
  logic wr_elig;
  logic rd_elig;

  // ------------------------------------------------------------------
  // Channel handshakes
  // ------------------------------------------------------------------

  assign s_awready_o = ~aw_full;
  assign s_wready_o  = ~w_full;
  assign s_arready_o = ~ar_full;

  assign aw_hs = s_awvalid_i & ~aw_full;
  assign w_hs  = s_wvalid_i & ~w_full;
  assign ar_hs = s_arvalid_i & ~ar_full;
  assign b_hs  = bvalid & s_bready_i;
  assign r_hs  = rvalid & s_rready_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      ar_full <= 1'b0;
    end
    else
    begin
      // Write slot halves fill on their own, empty together on B
      if (aw_hs)
        aw_full <= 1'b1;
      else if (b_hs)
        aw_full <= 1'b0;

      if (w_hs)
        w_full <= 1'b1;
      else if (b_hs)
        w_full <= 1'b0;

      if (ar_hs)
        ar_full <= 1'b1;
      else if (r_hs)
        ar_full <= 1'b0;
    end
  end

  // Word address taken from above the byte offset, upper bits alias
  always_ff @(posedge ACLK)
  begin
    if (aw_hs)
      aw_addr <= s_awaddr_i[OFFSET_BITS +: MEM_ADDR_WIDTH];
    if (w_hs)
    begin
      w_data <= s_wdata_i;
      w_strb <= s_wstrb_i;
    end
    if (ar_hs)
      ar_addr <= s_araddr_i[OFFSET_BITS +: MEM_ADDR_WIDTH];
    if (rdata_valid_i)
      r_data <= rdata_i;
  end

  // ------------------------------------------------------------------
  // Request and read/write round robin
  // ------------------------------------------------------------------

  assign wr_elig = aw_full & w_full & ~bvalid;
  assign rd_elig = ar_full & ~rd_pending & ~rvalid;

  assign req_valid_o = wr_elig | rd_elig;
  assign req_write_o = wr_elig & (~rd_elig | ~rr_flag);
  assign req_addr_o  = req_write_o ? aw_addr : ar_addr;
  assign req_wdata_o = w_data;
  assign req_be_o    = w_strb;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      rr_flag <= 1'b0;
    else if (grant_i)
      rr_flag <= ~rr_flag;
  end

  // ------------------------------------------------------------------
  // Responses
  // ------------------------------------------------------------------

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      rd_pending <= 1'b0;
    end
    else
    begin
      // Write is done in memory at the grant edge
      if (grant_i & req_write_o)
        bvalid <= 1'b1;
      else if (b_hs)
        bvalid <= 1'b0;

      // Read waits one cycle for the bank output
      if (grant_i & ~req_write_o)
        rd_pending <= 1'b1;
      else if (rdata_valid_i)
        rd_pending <= 1'b0;

      if (rdata_valid_i)
        rvalid <= 1'b1;
      else if (r_hs)
        rvalid <= 1'b0;
    end
  end

  assign s_bvalid_o = bvalid;
  assign s_bresp_o  = RESP_OKAY;
  assign s_rvalid_o = rvalid;
  assign s_rdata_o  = r_data;
  assign s_rresp_o  = RESP_OKAY;

endmodule

// File: mem_arbiter.sv
/* Fixed-priority memory arbiter */

`timescale 1ns/1ps

module mem_arbiter
  import mem_if_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
)
(
  input  logic                      ACLK,
  input  logic                      ARESETn,

  // High-priority request
  input  logic                      hp_req_valid_i,
  input  logic                      hp_req_write_i,
  input  logic [MEM_ADDR_WIDTH-1:0] hp_req_addr_i,
  input  data_t                     hp_req_wdata_i,
  input  strb_t                     hp_req_be_i,

  // Low-priority request
  input  logic                      lp_req_valid_i,
  input  logic                      lp_req_write_i,
  input  logic [MEM_ADDR_WIDTH-1:0] lp_req_addr_i,
  input  data_t                     lp_req_wdata_i,
  input  strb_t                     lp_req_be_i,

  output logic                      hp_grant_o,
  output logic                      lp_grant_o,

  // Memory side
  output logic                      mem_cs_o,
  output logic                      mem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0] mem_addr_o,
  output data_t                     mem_wdata_o,
  output strb_t                     mem_be_o,

  output logic                      hp_rdata_valid_o,
  output logic                      lp_rdata_valid_o
);

  // Read issued last cycle and the port it belongs to
  logic rd_inflight;
  logic rd_dest_hp;

  // ------------------------------------------------------------------
  // Grant and request mux
  // ------------------------------------------------------------------

  // hp wins whenever it asks
  assign hp_grant_o = hp_req_valid_i;
  assign lp_grant_o = lp_req_valid_i & ~hp_req_valid_i;

  always_comb
  begin
    mem_cs_o = hp_req_valid_i | lp_req_valid_i;
    if (hp_req_valid_i)
    begin
      mem_we_o    = hp_req_write_i;
      mem_addr_o  = hp_req_addr_i;
      mem_wdata_o = hp_req_wdata_i;
      mem_be_o    = hp_req_be_i;
    end
    else
    begin
      mem_we_o    = lp_req_write_i;
      mem_addr_o  = lp_req_addr_i;
      mem_wdata_o = lp_req_wdata_i;
      mem_be_o    = lp_req_be_i;
    end
  end

  // ------------------------------------------------------------------
  // Read-data return
  // ------------------------------------------------------------------

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      rd_inflight <= 1'b0;
      rd_dest_hp  <= 1'b0;
    end
    else
    begin
      rd_inflight <= mem_cs_o & ~mem_we_o;
      rd_dest_hp  <= hp_grant_o;
    end
  end

  assign hp_rdata_valid_o = rd_inflight & rd_dest_hp;
  assign lp_rdata_valid_o = rd_inflight & ~rd_dest_hp;

endmodule

// File: sram_bank.sv
/* Single-port SRAM bank */

`timescale 1ns/1ps

module sram_bank
  import mem_if_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
)
(
  input  logic                      ACLK,
  input  logic                      cs_i,
  input  logic                      we_i,
  input  logic [MEM_ADDR_WIDTH-1:0] addr_i,
  input  data_t                     wdata_i,
  input  strb_t                     be_i,
  output data_t                     rdata_o
);

  localparam int DEPTH = 2 ** MEM_ADDR_WIDTH;

  data_t mem [DEPTH];

  // Byte-lane write, registered read
  always_ff @(posedge ACLK)
  begin
    if (cs_i)
    begin
      if (we_i)
      begin
        for (int i = 0; i < STRB_WIDTH; i++)
        begin
          if (be_i[i])
            mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: mem_if_top.sv
/* Dual-port AXI4-Lite memory controller */

`timescale 1ns/1ps

module mem_if_top
  import mem_if_pkg::*;
#(
  parameter int MEM_ADDR_WIDTH = 8
)
(
  input  logic                  ACLK,
  input  logic                  ARESETn,

  // ------------------------------------------------------------------
  // High-priority port
  // ------------------------------------------------------------------
  input  logic [ADDR_WIDTH-1:0] hp_awaddr_i,
  input  logic                  hp_awvalid_i,
  output logic                  hp_awready_o,
  input  data_t                 hp_wdata_i,
  input  strb_t                 hp_wstrb_i,
  input  logic                  hp_wvalid_i,
  output logic                  hp_wready_o,
  output logic [1:0]            hp_bresp_o,
  output logic                  hp_bvalid_o,
  input  logic                  hp_bready_i,
  input  logic [ADDR_WIDTH-1:0] hp_araddr_i,
  input  logic                  hp_arvalid_i,
  output logic                  hp_arready_o,
  output data_t                 hp_rdata_o,
  output logic [1:0]            hp_rresp_o,
  output logic                  hp_rvalid_o,
  input  logic                  hp_rready_i,

  // ------------------------------------------------------------------
  // Low-priority port
  // ------------------------------------------------------------------
  input  logic [ADDR_WIDTH-1:0] lp_awaddr_i,
  input  logic                  lp_awvalid_i,
  output logic                  lp_awready_o,
  input  data_t                 lp_wdata_i,
  input  strb_t                 lp_wstrb_i,
  input  logic                  lp_wvalid_i,
  output logic                  lp_wready_o,
  output logic [1:0]            lp_bresp_o,
  output logic                  lp_bvalid_o,
  input  logic                  lp_bready_i,
  input  logic [ADDR_WIDTH-1:0] lp_araddr_i,
  input  logic                  lp_arvalid_i,
  output logic                  lp_arready_o,
  output data_t                 lp_rdata_o,
  output logic [1:0]            lp_rresp_o,
  output logic                  lp_rvalid_o,
  input  logic                  lp_rready_i
);

  // Port requests
  logic                      hp_req_valid;
  logic                      hp_req_write;
  logic [MEM_ADDR_WIDTH-1:0] hp_req_addr;
  data_t                     hp_req_wdata;
  strb_t                     hp_req_be;
  logic                      lp_req_valid;
  logic                      lp_req_write;
  logic [MEM_ADDR_WIDTH-1:0] lp_req_addr;
  data_t                     lp_req_wdata;
  strb_t                     lp_req_be;

  // Arbiter answers
  logic hp_grant;
  logic lp_grant;
  logic hp_rdata_valid;
  logic lp_rdata_valid;

  // Memory bus
  logic                      mem_cs;
  logic                      mem_we;
  logic [MEM_ADDR_WIDTH-1:0] mem_addr;
  data_t                     mem_wdata;
  strb_t                     mem_be;
  data_t                     mem_rdata;

  axil_port_slave #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_port_hp (
    .ACLK          (ACLK),
    .ARESETn       (ARESETn),
    .s_awaddr_i    (hp_awaddr_i),
    .s_awvalid_i   (hp_awvalid_i),
    .s_awready_o   (hp_awready_o),
    .s_wdata_i     (hp_wdata_i),
    .s_wstrb_i     (hp_wstrb_i),
    .s_wvalid_i    (hp_wvalid_i),
    .s_wready_o    (hp_wready_o),
    .s_bresp_o     (hp_bresp_o),
    .s_bvalid_o    (hp_bvalid_o),
    .s_bready_i    (hp_bready_i),
    .s_araddr_i    (hp_araddr_i),
    .s_arvalid_i   (hp_arvalid_i),
    .s_arready_o   (hp_arready_o),
    .s_rdata_o     (hp_rdata_o),
    .s_rresp_o     (hp_rresp_o),
    .s_rvalid_o    (hp_rvalid_o),
    .s_rready_i    (hp_rready_i),
    .req_valid_o   (hp_req_valid),
    .req_write_o   (hp_req_write),
    .req_addr_o    (hp_req_addr),
    .req_wdata_o   (hp_req_wdata),
    .req_be_o      (hp_req_be),
    .grant_i       (hp_grant),
    .rdata_valid_i (hp_rdata_valid),
    .rdata_i       (mem_rdata)
  );

  axil_port_slave #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_port_lp (
    .ACLK          (ACLK),
    .ARESETn       (ARESETn),
    .s_awaddr_i    (lp_awaddr_i),
    .s_awvalid_i   (lp_awvalid_i),
    .s_awready_o   (lp_awready_o),
    .s_wdata_i     (lp_wdata_i),
    .s_wstrb_i     (lp_wstrb_i),
    .s_wvalid_i    (lp_wvalid_i),
    .s_wready_o    (lp_wready_o),
    .s_bresp_o     (lp_bresp_o),
    .s_bvalid_o    (lp_bvalid_o),
    .s_bready_i    (lp_bready_i),
    .s_araddr_i    (lp_araddr_i),
    .s_arvalid_i   (lp_arvalid_i),
    .s_arready_o   (lp_arready_o),
    .s_rdata_o     (lp_rdata_o),
    .s_rresp_o     (lp_rresp_o),
    .s_rvalid_o    (lp_rvalid_o),
    .s_rready_i    (lp_rready_i),
    .req_valid_o   (lp_req_valid),
    .req_write_o   (lp_req_write),
    .req_addr_o    (lp_req_addr),
    .req_wdata_o   (lp_req_wdata),
    .req_be_o      (lp_req_be),
    .grant_i       (lp_grant),
    .rdata_valid_i (lp_rdata_valid),
    .rdata_i       (mem_rdata)
  );

  mem_arbiter #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_arbiter (
    .ACLK             (ACLK),
    .ARESETn          (ARESETn),
    .hp_req_valid_i   (hp_req_valid),
    .hp_req_write_i   (hp_req_write),
    .hp_req_addr_i    (hp_req_addr),
    .hp_req_wdata_i   (hp_req_wdata),
    .hp_req_be_i      (hp_req_be),
    .lp_req_valid_i   (lp_req_valid),
    .lp_req_write_i   (lp_req_write),
    .lp_req_addr_i    (lp_req_addr),
    .lp_req_wdata_i   (lp_req_wdata),
    .lp_req_be_i      (lp_req_be),
    .hp_grant_o       (hp_grant),
    .lp_grant_o       (lp_grant),
    .mem_cs_o         (mem_cs),
    .mem_we_o         (mem_we),
    .mem_addr_o       (mem_addr),
    .mem_wdata_o      (mem_wdata),
    .mem_be_o         (mem_be),
    .hp_rdata_valid_o (hp_rdata_valid),
    .lp_rdata_valid_o (lp_rdata_valid)
  );

  sram_bank #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_bank (
    .ACLK    (ACLK),
    .cs_i    (mem_cs),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

endmodule

// File: tb_mem_if.sv
/* Memory controller testbench */

`timescale 1ns/1ps

module tb_mem_if;
  import mem_if_pkg::*;

  localparam int MEM_ADDR_WIDTH = 8;
  localparam int DEPTH          = 2 ** MEM_ADDR_WIDTH;
  localparam int TIMEOUT        = 200;

  logic ACLK;
  logic ARESETn;

  // Index 0 is the hp port, index 1 the lp port
  logic [ADDR_WIDTH-1:0] awaddr [2];
  logic [ADDR_WIDTH-1:0] araddr [2];
  data_t                 wdata [2];
  strb_t                 wstrb [2];
  logic [1:0]            awvalid;
  logic [1:0]            wvalid;
  logic [1:0]            bready;
  logic [1:0]            arvalid;
  logic [1:0]            rready;

  logic       awready_v [2];
  logic       wready_v [2];
  logic       bvalid_v [2];
  logic       arready_v [2];
  logic       rvalid_v [2];
  logic [1:0] bresp_v [2];
  logic [1:0] rresp_v [2];
  data_t      rdata_v [2];

  // Reference memory and scoreboard state
  data_t model [DEPTH];
  logic  written [DEPTH];
  data_t exp_rdata [2];
  data_t r_held [2];
  logic  r_wait [2];
  logic  b_wait [2];
  int    r_seen [2];
  int    seed;
  int    errors;
  int    checks;
  int    mark;
  int    cycle = 0;

  mem_if_top #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_mem_if_top (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .hp_awaddr_i  (awaddr[0]),
    .hp_awvalid_i (awvalid[0]),
    .hp_awready_o (awready_v[0]),
    .hp_wdata_i   (wdata[0]),
    .hp_wstrb_i   (wstrb[0]),
    .hp_wvalid_i  (wvalid[0]),
    .hp_wready_o  (wready_v[0]),
    .hp_bresp_o   (bresp_v[0]),
    .hp_bvalid_o  (bvalid_v[0]),
    .hp_bready_i  (bready[0]),
    .hp_araddr_i  (araddr[0]),
    .hp_arvalid_i (arvalid[0]),
    .hp_arready_o (arready_v[0]),
    .hp_rdata_o   (rdata_v[0]),
    .hp_rresp_o   (rresp_v[0]),
    .hp_rvalid_o  (rvalid_v[0]),
    .hp_rready_i  (rready[0]),
    .lp_awaddr_i  (awaddr[1]),
    .lp_awvalid_i (awvalid[1]),
    .lp_awready_o (awready_v[1]),
    .lp_wdata_i   (wdata[1]),
    .lp_wstrb_i   (wstrb[1]),
    .lp_wvalid_i  (wvalid[1]),
    .lp_wready_o  (wready_v[1]),
    .lp_bresp_o   (bresp_v[1]),
    .lp_bvalid_o  (bvalid_v[1]),
    .lp_bready_i  (bready[1]),
    .lp_araddr_i  (araddr[1]),
    .lp_arvalid_i (arvalid[1]),
    .lp_arready_o (arready_v[1]),
    .lp_rdata_o   (rdata_v[1]),
    .lp_rresp_o   (rresp_v[1]),
    .lp_rvalid_o  (rvalid_v[1]),
    .lp_rready_i  (rready[1])
  );

  always
  begin
    #10 ACLK = ~ACLK;
  end

  always @(posedge ACLK)
  begin
    cycle <= cycle + 1;
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  // Upper address bits alias onto the low word address
  function automatic int word_index(input logic [ADDR_WIDTH-1:0] addr);
    return int'((addr >> OFFSET_BITS) % DEPTH);
  endfunction

  // Byte lanes with a strobe take the new data
  function automatic data_t merge_word(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t w;
    w = old_w;
    for (int i = 0; i < STRB_WIDTH; i++)
    begin
      if (strb[i])
        w[8*i +: 8] = new_w[8*i +: 8];
    end
    return w;
  endfunction

  function automatic string port_name(input int p);
    return (p == 0) ? "hp" : "lp";
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED @%0t: %s", $time, msg);
  endtask

  task automatic timed_out(input string what, input int p);
    $display("Timeout on the %s port while waiting for %s at %0t", port_name(p), what, $time);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic close_test(input string name);
    $display("%-28s %s, %0d errors", name, (errors == mark) ? "ok" : "bad", errors - mark);
    mark = errors;
  endtask

  // ------------------------------------------------------------------
  // AXI4-Lite master tasks
  // ------------------------------------------------------------------

  task automatic write_word(input int p, input logic [ADDR_WIDTH-1:0] addr, input data_t data,
                            input strb_t strb, input int stall);
    int   n;
    int   idx;
    logic aw_done;
    logic w_done;
    logic aw_hit;
    logic w_hit;
    idx = word_index(addr);
    model[idx] = merge_word(model[idx], data, strb);
    if (&strb)
      written[idx] = 1'b1;
    @(posedge ACLK);
    awaddr[p]  <= addr;
    awvalid[p] <= 1'b1;
    wdata[p]   <= data;
    wstrb[p]   <= strb;
    wvalid[p]  <= 1'b1;
    aw_done = 1'b0;
    w_done  = 1'b0;
    n = 0;
    while (!(aw_done && w_done))
    begin
      if (n >= TIMEOUT)
        timed_out("AWREADY and WREADY", p);
      @(negedge ACLK);
      aw_hit = !aw_done && awready_v[p];
      w_hit  = !w_done && wready_v[p];
      @(posedge ACLK);
      if (aw_hit)
      begin
        awvalid[p] <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hit)
      begin
        wvalid[p] <= 1'b0;
        w_done = 1'b1;
      end
      n++;
    end
    n = 0;
    @(negedge ACLK);
    while (!bvalid_v[p])
    begin
      if (n >= TIMEOUT)
        timed_out("BVALID", p);
      @(negedge ACLK);
      n++;
    end
    // Response held back for a while to exercise back-pressure
    repeat (stall) @(posedge ACLK);
    @(posedge ACLK);
    bready[p] <= 1'b1;
    @(posedge ACLK);
    bready[p] <= 1'b0;
  endtask

  task automatic read_word(input int p, input logic [ADDR_WIDTH-1:0] addr, input int stall);
    int n;
    exp_rdata[p] = model[word_index(addr)];
    @(posedge ACLK);
    araddr[p]  <= addr;
    arvalid[p] <= 1'b1;
    n = 0;
    @(negedge ACLK);
    while (!arready_v[p])
    begin
      if (n >= TIMEOUT)
        timed_out("ARREADY", p);
      @(negedge ACLK);
      n++;
    end
    @(posedge ACLK);
    arvalid[p] <= 1'b0;
    n = 0;
    @(negedge ACLK);
    while (!rvalid_v[p])
    begin
      if (n >= TIMEOUT)
        timed_out("RVALID", p);
      @(negedge ACLK);
      n++;
    end
    r_seen[p] = cycle;
    repeat (stall) @(posedge ACLK);
    @(posedge ACLK);
    rready[p] <= 1'b1;
    @(posedge ACLK);
    rready[p] <= 1'b0;
  endtask

  // Random mix inside a 64-word window of one port
  task automatic random_traffic(input int p, input int base, input int count, input logic stalls);
    int                    off;
    int                    idx;
    int                    stall;
    logic [ADDR_WIDTH-1:0] addr;
    data_t                 data;
    strb_t                 strb;
    for (int k = 0; k < count; k++)
    begin
      off   = $random(seed) & 63;
      idx   = base + off;
      addr  = idx << OFFSET_BITS;
      stall = stalls ? ($random(seed) & 7) : 0;
      data  = $random(seed);
      strb  = strb_t'($random(seed));
      if (written[idx] && ($random(seed) & 1))
        read_word(p, addr, stall);
      else
        write_word(p, addr, data, written[idx] ? strb : 4'hF, stall);
    end
  endtask

  // ------------------------------------------------------------------
  // Response checker
  // ------------------------------------------------------------------

  always @(negedge ACLK)
  begin
    if (ARESETn)
    begin
      for (int p = 0; p < 2; p++)
      begin
        if (r_wait[p])
          assert (rvalid_v[p] && rdata_v[p] == r_held[p])
          else report_error($sformatf("%s R channel changed before RREADY", port_name(p)));
        if (b_wait[p])
          assert (bvalid_v[p])
          else report_error($sformatf("%s BVALID dropped before BREADY", port_name(p)));
        if (bvalid_v[p])
          assert (!awready_v[p] && !wready_v[p] && bresp_v[p] == RESP_OKAY)
          else report_error($sformatf("%s write slot or BRESP wrong", port_name(p)));
        if (rvalid_v[p])
          assert (!arready_v[p] && rresp_v[p] == RESP_OKAY)
          else report_error($sformatf("%s ARREADY or RRESP wrong", port_name(p)));
        if (bvalid_v[p] && bready[p])
          checks++;
        if (rvalid_v[p] && rready[p])
        begin
          checks++;
          assert (rdata_v[p] == exp_rdata[p])
          else report_error($sformatf("%s rdata %h, expected %h", port_name(p), rdata_v[p],
                                      exp_rdata[p]));
        end
        b_wait[p] = bvalid_v[p] && !bready[p];
        r_wait[p] = rvalid_v[p] && !rready[p];
        r_held[p] = rdata_v[p];
      end
    end
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial
  begin
    ACLK    = 1'b0;
    ARESETn = 1'b0;
    seed    = 74;
    errors  = 0;
    checks  = 0;
    mark    = 0;
    awvalid = '0;
    wvalid  = '0;
    bready  = '0;
    arvalid = '0;
    rready  = '0;
    for (int p = 0; p < 2; p++)
    begin
      awaddr[p] = '0;
      araddr[p] = '0;
      wdata[p]  = '0;
      wstrb[p]  = '0;
      r_wait[p] = 1'b0;
      b_wait[p] = 1'b0;
    end
    for (int i = 0; i < DEPTH; i++)
      written[i] = 1'b0;
    repeat (16) @(posedge ACLK);
    ARESETn <= 1'b1;
    @(negedge ACLK);

    for (int p = 0; p < 2; p++)
    begin
      checks++;
      assert (!bvalid_v[p] && !rvalid_v[p] && awready_v[p] && wready_v[p] && arready_v[p])
      else report_error($sformatf("%s outputs wrong after reset", port_name(p)));
    end
    close_test("reset state");

    for (int p = 0; p < 2; p++)
    begin
      write_word(p, 32'h40 + p * 32'h100, 32'hA5A5_0000 + p, 4'hF, 0);
      read_word(p, 32'h40 + p * 32'h100, 0);
      // Bits above the memory depth are dropped
      write_word(p, 32'hFFFF_F020 + p * 32'h100, 32'h5A5A_1234 + p, 4'hF, 0);
      read_word(p, 32'h20 + p * 32'h100, 0);
    end
    close_test("write, read and alias");

    for (int p = 0; p < 2; p++)
    begin
      write_word(p, 32'h60 + p * 32'h100, 32'h1122_3344, 4'hF, 0);
      write_word(p, 32'h60 + p * 32'h100, 32'hAABB_CCDD, 4'b0101, 0);
      read_word(p, 32'h60 + p * 32'h100, 0);
    end
    close_test("partial strobe");

    fork
      read_word(0, 32'h40, 0);
      read_word(1, 32'h140, 0);
    join
    checks++;
    assert (r_seen[0] <= r_seen[1])
    else report_error($sformatf("hp RVALID at cycle %0d after lp at %0d", r_seen[0], r_seen[1]));
    write_word(1, 32'h144, 32'hC0DE_0001, 4'hF, 0);
    read_word(1, 32'h144, 0);
    close_test("priority");

    fork
      random_traffic(0, 0, 24, 1'b0);
      random_traffic(1, 64, 24, 1'b0);
    join
    close_test("random traffic");

    fork
      random_traffic(0, 0, 12, 1'b1);
      random_traffic(1, 64, 12, 1'b1);
    join
    close_test("back-pressure");

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: build.f
mem_if_pkg.sv
axil_port_slave.sv
mem_arbiter.sv
sram_bank.sv
mem_if_top.sv
tb_mem_if.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mem_if -f build.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
